/* source/loader_macros.svh */
`ifndef LOADER_MACROS_SVH
`define LOADER_MACROS_SVH

// processing columns, each owning a control and an immediate table
`define NUM_COL 2

// tables loaded by the sequencer: state table plus two per column
`define NUM_TABLE (2 * `NUM_COL + 1)

// width of one staged load word
`define WORD_W 32

// table entry address, 64 entries per table and in the inbound buffer
`define TABLE_ADDR_W 6

// staging memory address, 512 words
`define STAGE_ADDR_W 9

// read port table selector, covers all tables plus the inbound buffer
`define TABLE_SEL_W 3

`endif

/* source/loader_pkg.sv */
`include "loader_macros.svh"

package loader_pkg;

    // raw word as written by the host into staging
    typedef logic [`WORD_W-1:0] load_word_t;

    // per-column control table entry
    typedef struct packed {
        logic [7:0] opcode;
        logic [7:0] src_a;
        logic [7:0] src_b;
        logic [7:0] dest;
    } control_entry_t;

    // per-column immediate table entry
    typedef struct packed {
        logic [15:0] imm;
        logic [7:0]  shift;
        logic [7:0]  flags;
    } imm_entry_t;

    // state table entry
    typedef struct packed {
        logic [23:0] value;
        logic [7:0]  tag;
    } state_entry_t;

    // inbound data buffer word
    typedef struct packed {
        logic [23:0] payload;
        logic [7:0]  src_tag;
    } inbound_word_t;

    // load sequencer states
    // tables first, then inbound words, then a single done cycle
    typedef enum logic [1:0] {
        IDLE,
        LOAD_TABLES,
        LOAD_INBOUND,
        DONE
    } load_state_t;

endpackage

/* source/load_sequencer.sv */
`timescale 1ns/1ps

`include "loader_macros.svh"

module load_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic [`TABLE_ADDR_W-1:0] num_entry_config_table,
    input  logic [`TABLE_ADDR_W-1:0] num_entry_inbound,
    output logic [`STAGE_ADDR_W-1:0] stage_add,
    output logic [`TABLE_ADDR_W-1:0] tbl_wr_add,
    output logic [`NUM_TABLE-1:0]    tbl_wr_en,
    output logic [`TABLE_ADDR_W-1:0] in_wr_add,
    output logic                     in_wr_en,
    output logic                     busy,
    output logic                     done
);
    import loader_pkg::*;

    load_state_t state;

    // counts latched on start
    logic [`TABLE_ADDR_W-1:0] n_cfg;
    logic [`TABLE_ADDR_W-1:0] n_in;

    // entry within current table, wraps at n_cfg-1
    logic [`TABLE_ADDR_W-1:0] entry_cnt;
    // one-hot pointer to the table being written
    logic [`NUM_TABLE-1:0]    tbl_ptr;
    // inbound word index, wraps at n_in-1
    logic [`TABLE_ADDR_W-1:0] in_cnt;
    // flat staging index, one step per write
    logic [`STAGE_ADDR_W-1:0] stage_cnt;

    logic last_entry;
    logic last_table;
    logic last_inbound;

    assign last_entry   = (entry_cnt == n_cfg - 1'b1);
    assign last_table   = tbl_ptr[`NUM_TABLE-1];
    assign last_inbound = (in_cnt == n_in - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            n_cfg     <= '0;
            n_in      <= '0;
            entry_cnt <= '0;
            tbl_ptr   <= '0;
            in_cnt    <= '0;
            stage_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // start ignored outside idle
                    if (start) begin
                        n_cfg     <= num_entry_config_table;
                        n_in      <= num_entry_inbound;
                        entry_cnt <= '0;
                        in_cnt    <= '0;
                        stage_cnt <= '0;
                        // state table goes first
                        tbl_ptr   <= {{(`NUM_TABLE-1){1'b0}}, 1'b1};
                        state     <= LOAD_TABLES;
                    end
                end
                LOAD_TABLES: begin
                    stage_cnt <= stage_cnt + 1'b1;
                    if (last_entry) begin
                        entry_cnt <= '0;
                        if (last_table) begin
                            tbl_ptr <= '0;
                            state   <= LOAD_INBOUND;
                        end else begin
                            // next table in load order
                            tbl_ptr <= tbl_ptr << 1;
                        end
                    end else begin
                        entry_cnt <= entry_cnt + 1'b1;
                    end
                end
                LOAD_INBOUND: begin
                    // staging index carries on past the last table
                    stage_cnt <= stage_cnt + 1'b1;
                    if (last_inbound) begin
                        in_cnt <= '0;
                        state  <= DONE;
                    end else begin
                        in_cnt <= in_cnt + 1'b1;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign stage_add  = stage_cnt;
    assign tbl_wr_add = entry_cnt;
    assign in_wr_add  = in_cnt;

    // enables only inside their load phase
    assign tbl_wr_en = (state == LOAD_TABLES) ? tbl_ptr : '0;
    assign in_wr_en  = (state == LOAD_INBOUND);

    assign busy = (state == LOAD_TABLES) || (state == LOAD_INBOUND);
    // single cycle pulse
    assign done = (state == DONE);

endmodule

/* source/staging_buffer.sv */
`timescale 1ns/1ps

`include "loader_macros.svh"

module staging_buffer (
    input  logic                     clk,
    input  logic                     busy,
    input  logic                     host_wr_en,
    input  logic [`STAGE_ADDR_W-1:0] host_wr_add,
    input  loader_pkg::load_word_t   host_wr_data,
    input  logic [`STAGE_ADDR_W-1:0] stage_add,
    output loader_pkg::load_word_t   stage_data
);
    import loader_pkg::*;

    // tables back to back, inbound words after the last table
    load_word_t mem [0:(1 << `STAGE_ADDR_W)-1];

    // host side write
    // dropped while the sequencer walks the memory
    always_ff @(posedge clk) begin
        if (host_wr_en && !busy) begin
            mem[host_wr_add] <= host_wr_data;
        end
    end

    // async read so data meets the table write strobe in the same cycle
    assign stage_data = mem[stage_add];

endmodule

/* source/table_bank.sv */
`timescale 1ns/1ps

`include "loader_macros.svh"

module table_bank #(
    parameter type entry_t = loader_pkg::load_word_t
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [`TABLE_ADDR_W-1:0] wr_add,
    input  entry_t                   wr_data,
    input  logic [`TABLE_ADDR_W-1:0] rd_add,
    output entry_t                   rd_data
);

    // one table, payload type set per instance
    entry_t mem [0:(1 << `TABLE_ADDR_W)-1];

    // single write port fed by the sequencer
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_add] <= wr_data;
        end
    end

    // registered read
    // same-cycle write and read of one entry gives the old value
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_add];
    end

endmodule

/* source/table_read_mux.sv */
`timescale 1ns/1ps

`include "loader_macros.svh"

module table_read_mux (
    input  logic                       clk,
    input  logic [`TABLE_SEL_W-1:0]    rd_table,
    input  loader_pkg::state_entry_t   state_rd,
    input  loader_pkg::control_entry_t ctrl_rd [0:`NUM_COL-1],
    input  loader_pkg::imm_entry_t     imm_rd [0:`NUM_COL-1],
    input  loader_pkg::inbound_word_t  in_rd,
    output loader_pkg::load_word_t     rd_data
);
    import loader_pkg::*;

    // selector value naming the inbound buffer
    localparam logic [`TABLE_SEL_W-1:0] inbound_sel = `TABLE_SEL_W'(`NUM_TABLE);

    // selector delayed to match the banks' registered read
    logic [`TABLE_SEL_W-1:0] sel_q;

    always_ff @(posedge clk) begin
        sel_q <= rd_table;
    end

    // 0 state, 2c+1 control of column c, 2c+2 immediate of column c
    always_comb begin
        // out of range reads back zero
        rd_data = '0;
        if (sel_q == '0) begin
            rd_data = load_word_t'(state_rd);
        end else if (sel_q == inbound_sel) begin
            rd_data = load_word_t'(in_rd);
        end
        for (int c = 0; c < `NUM_COL; c++) begin
            if (sel_q == `TABLE_SEL_W'(2 * c + 1)) begin
                rd_data = load_word_t'(ctrl_rd[c]);
            end
            if (sel_q == `TABLE_SEL_W'(2 * c + 2)) begin
                rd_data = load_word_t'(imm_rd[c]);
            end
        end
    end

endmodule

/* source/table_loader_top.sv */
`timescale 1ns/1ps

`include "loader_macros.svh"

module table_loader_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic [`TABLE_ADDR_W-1:0] num_entry_config_table,
    input  logic [`TABLE_ADDR_W-1:0] num_entry_inbound,
    input  logic                     host_wr_en,
    input  logic [`STAGE_ADDR_W-1:0] host_wr_add,
    input  loader_pkg::load_word_t   host_wr_data,
    input  logic [`TABLE_SEL_W-1:0]  rd_table,
    input  logic [`TABLE_ADDR_W-1:0] rd_add,
    output loader_pkg::load_word_t   rd_data,
    output logic                     busy,
    output logic                     done
);
    import loader_pkg::*;

    logic [`STAGE_ADDR_W-1:0] stage_add;
    load_word_t               stage_data;
    logic [`TABLE_ADDR_W-1:0] tbl_wr_add;
    logic [`NUM_TABLE-1:0]    tbl_wr_en;
    logic [`TABLE_ADDR_W-1:0] in_wr_add;
    logic                     in_wr_en;

    // bank read outputs toward the mux
    state_entry_t   state_rd;
    control_entry_t ctrl_rd [0:`NUM_COL-1];
    imm_entry_t     imm_rd [0:`NUM_COL-1];
    inbound_word_t  in_rd;

    load_sequencer u_seq (
        .clk                    (clk),
        .rst                    (rst),
        .start                  (start),
        .num_entry_config_table (num_entry_config_table),
        .num_entry_inbound      (num_entry_inbound),
        .stage_add              (stage_add),
        .tbl_wr_add             (tbl_wr_add),
        .tbl_wr_en              (tbl_wr_en),
        .in_wr_add              (in_wr_add),
        .in_wr_en               (in_wr_en),
        .busy                   (busy),
        .done                   (done)
    );

    staging_buffer u_stage (
        .clk          (clk),
        .busy         (busy),
        .host_wr_en   (host_wr_en),
        .host_wr_add  (host_wr_add),
        .host_wr_data (host_wr_data),
        .stage_add    (stage_add),
        .stage_data   (stage_data)
    );

    // table 0, state table
    table_bank #(.entry_t(state_entry_t)) u_state_bank (
        .clk     (clk),
        .wr_en   (tbl_wr_en[0]),
        .wr_add  (tbl_wr_add),
        .wr_data (state_entry_t'(stage_data)),
        .rd_add  (rd_add),
        .rd_data (state_rd)
    );

    // per column: control at 2c+1, immediate at 2c+2
    for (genvar c = 0; c < `NUM_COL; c++) begin : g_col
        table_bank #(.entry_t(control_entry_t)) u_ctrl_bank (
            .clk     (clk),
            .wr_en   (tbl_wr_en[2*c+1]),
            .wr_add  (tbl_wr_add),
            .wr_data (control_entry_t'(stage_data)),
            .rd_add  (rd_add),
            .rd_data (ctrl_rd[c])
        );

        table_bank #(.entry_t(imm_entry_t)) u_imm_bank (
            .clk     (clk),
            .wr_en   (tbl_wr_en[2*c+2]),
            .wr_add  (tbl_wr_add),
            .wr_data (imm_entry_t'(stage_data)),
            .rd_add  (rd_add),
            .rd_data (imm_rd[c])
        );
    end

    // inbound buffer, loaded after all tables
    table_bank #(.entry_t(inbound_word_t)) u_in_bank (
        .clk     (clk),
        .wr_en   (in_wr_en),
        .wr_add  (in_wr_add),
        .wr_data (inbound_word_t'(stage_data)),
        .rd_add  (rd_add),
        .rd_data (in_rd)
    );

    table_read_mux u_rd_mux (
        .clk      (clk),
        .rd_table (rd_table),
        .state_rd (state_rd),
        .ctrl_rd  (ctrl_rd),
        .imm_rd   (imm_rd),
        .in_rd    (in_rd),
        .rd_data  (rd_data)
    );

endmodule

/* test/tb_table_loader.sv */
`timescale 1ns/1ps

`include "loader_macros.svh"

module tb_table_loader;
    import loader_pkg::*;

    localparam int stage_depth = 1 << `STAGE_ADDR_W;
    localparam int tbl_depth   = 1 << `TABLE_ADDR_W;
    // largest load in the tests, N=8 and M=5
    localparam int full_load   = `NUM_TABLE * 8 + 5;
    // reset, idle, two fills, three loads with margin, three two-cycle readbacks
    localparam int cycle_limit = 14 + 2 * (full_load + 2) + 3 * (full_load + 10)
                                 + 3 * (2 * full_load + 2) + 100;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     start;
    logic [`TABLE_ADDR_W-1:0] num_entry_config_table;
    logic [`TABLE_ADDR_W-1:0] num_entry_inbound;
    logic                     host_wr_en;
    logic [`STAGE_ADDR_W-1:0] host_wr_add;
    load_word_t               host_wr_data;
    logic [`TABLE_SEL_W-1:0]  rd_table;
    logic [`TABLE_ADDR_W-1:0] rd_add;
    load_word_t               rd_data;
    logic                     busy;
    logic                     done;

    // sequencer state, only for the debug print
    load_state_t seq_state;

    // host view of staging and the expected table contents
    load_word_t stage_copy [0:stage_depth-1];
    load_word_t exp_tbl [0:`NUM_TABLE-1][0:tbl_depth-1];
    load_word_t exp_in [0:tbl_depth-1];

    logic [31:0] lcg_state = 32'h7a1f;
    int word_errors   = 0;
    int flag_errors   = 0;
    int timing_errors = 0;
    int cycle_cnt     = 0;

    table_loader_top uut (
        .clk                    (clk),
        .rst                    (rst),
        .start                  (start),
        .num_entry_config_table (num_entry_config_table),
        .num_entry_inbound      (num_entry_inbound),
        .host_wr_en             (host_wr_en),
        .host_wr_add            (host_wr_add),
        .host_wr_data           (host_wr_data),
        .rd_table               (rd_table),
        .rd_add                 (rd_add),
        .rd_data                (rd_data),
        .busy                   (busy),
        .done                   (done)
    );

    assign seq_state = uut.u_seq.state;

    always #10 clk = ~clk;

    // hang guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == cycle_limit) begin
            $display("run stopped, still running after %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    function automatic load_word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_word(input string name, input load_word_t got,
                              input load_word_t exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            word_errors++;
        end
    endtask

    task automatic check_flags(input logic got_done, input logic got_busy,
                               input logic exp_done, input logic exp_busy);
        if (got_done !== exp_done) begin
            $display("** Error: done got %h expected %h", got_done, exp_done);
            flag_errors++;
        end
        if (got_busy !== exp_busy) begin
            $display("** Error: busy got %h expected %h", got_busy, exp_busy);
            flag_errors++;
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            timing_errors++;
        end
    endtask

    // staged words for tables back to back, inbound words after them
    task automatic fill_stage(input int n, input int m);
        load_word_t w;
        for (int a = 0; a < `NUM_TABLE * n + m; a++) begin
            w = lcg_next();
            stage_copy[a] = w;
            @(posedge clk);
            host_wr_en   <= 1'b1;
            host_wr_add  <= `STAGE_ADDR_W'(a);
            host_wr_data <= w;
        end
        @(posedge clk);
        host_wr_en <= 1'b0;
    endtask

    // table t entry a from t*N+a, inbound j from T*N+j
    task automatic update_model(input int n, input int m);
        for (int t = 0; t < `NUM_TABLE; t++) begin
            for (int a = 0; a < n; a++) begin
                exp_tbl[t][a] = stage_copy[t * n + a];
            end
        end
        for (int j = 0; j < m; j++) begin
            exp_in[j] = stage_copy[`NUM_TABLE * n + j];
        end
    endtask

    // optional host writes and a stray start while busy
    task automatic run_load(input int n, input int m, input bit corrupt, input bit poke);
        int edges;
        int busy_cnt;
        int exp_edges;
        exp_edges = `NUM_TABLE * n + m + 1;
        @(posedge clk);
        num_entry_config_table <= `TABLE_ADDR_W'(n);
        num_entry_inbound      <= `TABLE_ADDR_W'(m);
        start                  <= 1'b1;
        // this edge samples start, counted as edge 1
        @(posedge clk);
        start <= 1'b0;
        edges    = 1;
        busy_cnt = 0;
        @(negedge clk);
        while (!done && edges <= exp_edges + 4) begin
            if (busy) begin
                busy_cnt++;
            end
            @(posedge clk);
            edges++;
            start        <= poke && (edges == 10);
            host_wr_en   <= corrupt && (edges < 30);
            host_wr_add  <= `STAGE_ADDR_W'(edges);
            host_wr_data <= ~lcg_next();
            @(negedge clk);
        end
        // done up and busy already low in the done cycle
        check_flags(done, busy, 1'b1, 1'b0);
        check_cycles("done edge", edges, exp_edges);
        check_cycles("busy cycles", busy_cnt, exp_edges - 1);
        @(posedge clk);
        start      <= 1'b0;
        host_wr_en <= 1'b0;
        @(negedge clk);
        // done lasts one cycle
        check_flags(done, busy, 1'b0, 1'b0);
        $display("load n=%0d m=%0d over, sequencer in %s", n, m, seq_state.name());
    endtask

    task automatic read_entry(input int sel, input int add, input load_word_t exp);
        @(posedge clk);
        rd_table <= `TABLE_SEL_W'(sel);
        rd_add   <= `TABLE_ADDR_W'(add);
        // one cycle read latency
        @(posedge clk);
        @(negedge clk);
        check_word($sformatf("rd_data table %0d entry %0d", sel, add), rd_data, exp);
    endtask

    // 8 entries per table and 5 inbound words, the widest load used
    task automatic check_contents();
        for (int t = 0; t < `NUM_TABLE; t++) begin
            for (int a = 0; a < 8; a++) begin
                read_entry(t, a, exp_tbl[t][a]);
            end
        end
        for (int j = 0; j < 5; j++) begin
            read_entry(`NUM_TABLE, j, exp_in[j]);
        end
    endtask

    task automatic idle_check();
        repeat (10) begin
            @(negedge clk);
            check_flags(done, busy, 1'b0, 1'b0);
        end
    endtask

    initial begin
        rst                    <= 1'b1;
        start                  <= 1'b0;
        num_entry_config_table <= '0;
        num_entry_inbound      <= '0;
        host_wr_en             <= 1'b0;
        host_wr_add            <= '0;
        host_wr_data           <= '0;
        rd_table               <= '0;
        rd_add                 <= '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        idle_check();

        // first load with host writes landing while busy
        fill_stage(8, 5);
        run_load(8, 5, 1'b1, 1'b0);
        update_model(8, 5);
        check_contents();

        // same counts again, staging must be untouched, stray start ignored
        run_load(8, 5, 1'b0, 1'b1);
        check_contents();

        // smaller load rewrites only the low entries
        fill_stage(3, 1);
        run_load(3, 1, 1'b0, 1'b0);
        update_model(3, 1);
        check_contents();

        $display("errors: rd_data %0d, done/busy %0d, timing %0d",
                 word_errors, flag_errors, timing_errors);
        if (word_errors + flag_errors + timing_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+source
source/loader_pkg.sv
source/load_sequencer.sv
source/staging_buffer.sv
source/table_bank.sv
source/table_read_mux.sv
source/table_loader_top.sv
test/tb_table_loader.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing
TOP      = tb_table_loader
FILELIST = src.f
BUILD    = obj_dir
PASS     = Test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS)$$"

clean:
	rm -rf $(BUILD)
